//--- src/window_pkg.sv
package window_pkg;

    localparam int DATA_WIDTH   = 16;
    localparam int CONV_UNITS   = 4;
    localparam int KERNEL_H_MAX = 3;
    localparam int ADDR_WIDTH   = 6;

    // one input word covers every tap of the vertical kernel.
    localparam int IN_PIXELS = CONV_UNITS + KERNEL_H_MAX - 1;
    localparam int IN_WIDTH  = DATA_WIDTH * IN_PIXELS;
    localparam int OUT_WIDTH = DATA_WIDTH * CONV_UNITS;

    localparam int KH_WIDTH  = $clog2(KERNEL_H_MAX);
    localparam int BLK_WIDTH = 6;

    typedef struct packed {
        logic [KH_WIDTH-1:0]   kernel_h_1;  // taps minus one.
        logic [BLK_WIDTH-1:0]  blocks_1;    // input words minus one.
        logic [ADDR_WIDTH-1:0] in_base;
        logic [ADDR_WIDTH-1:0] out_base;
        logic                  is_relu;
        logic                  pad;
    } conv_cfg_t;

    typedef struct packed {
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [IN_WIDTH-1:0]   wdata;
    } mem_req_t;

    // one shifted output word on its way to the store.
    typedef struct packed {
        logic [OUT_WIDTH-1:0] data;
        logic [KH_WIDTH-1:0]  shift;
        logic                 last;
    } win_beat_t;

endpackage

//--- src/buffer_mem.sv
`timescale 1ns/1ps

module buffer_mem #(
    parameter int ADDR_WIDTH = window_pkg::ADDR_WIDTH,
    parameter int WORD_WIDTH = window_pkg::IN_WIDTH
) (
    input  logic                  aclk,
    input  window_pkg::mem_req_t  mem_req,
    input  logic                  mem_en,
    output logic [WORD_WIDTH-1:0] rdata
);

    logic [WORD_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // read data holds until the next granted read.
    always_ff @(posedge aclk) begin
        if (mem_en) begin
            if (mem_req.we) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                rdata <= mem[mem_req.addr];
            end
        end
    end

    // a write with an unknown address would corrupt the whole array.
    assert property (@(posedge aclk)
        mem_en && mem_req.we |-> !$isunknown(mem_req.addr))
    else $error("buffer_mem: write with unknown address.");

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                 aclk,
    input  logic                 rst_n,
    input  logic                 store_valid,
    input  window_pkg::mem_req_t store_req,
    input  logic                 fetch_valid,
    input  window_pkg::mem_req_t fetch_req,
    input  logic                 host_valid,
    input  window_pkg::mem_req_t host_req,
    output logic                 store_grant,
    output logic                 fetch_grant,
    output logic                 host_grant,
    output logic                 mem_en,
    output window_pkg::mem_req_t mem_req
);

    // store drains first so the shift buffer never backs up for long.
    always_comb begin
        store_grant = store_valid;
        fetch_grant = fetch_valid & ~store_valid;
        host_grant  = host_valid & ~store_valid & ~fetch_valid;
        mem_en      = store_valid | fetch_valid | host_valid;
    end

    always_comb begin
        if (store_valid) begin
            mem_req = store_req;
        end else if (fetch_valid) begin
            mem_req = fetch_req;
        end else begin
            mem_req    = host_req;
            mem_req.we = host_req.we & host_valid;  // no stray write when idle.
        end
    end

    // the host keeps its request steady until the grant arrives.
    assert property (@(posedge aclk) disable iff (!rst_n)
        host_valid && !host_grant |=> host_valid && $stable(host_req))
    else $error("mem_arbiter: host request changed before grant.");

endmodule

//--- src/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch #(
    parameter int ADDR_WIDTH = window_pkg::ADDR_WIDTH,
    parameter int WORD_WIDTH = window_pkg::IN_WIDTH
) (
    input  logic                             aclk,
    input  logic                             rst_n,
    input  logic                             launch,
    input  logic [ADDR_WIDTH-1:0]            in_base,
    input  logic [window_pkg::BLK_WIDTH-1:0] blocks_1,
    input  logic                             fetch_grant,
    input  logic [WORD_WIDTH-1:0]            rdata,
    input  logic                             in_ready,
    output logic                             fetch_valid,
    output window_pkg::mem_req_t             fetch_req,
    output logic                             in_valid,
    output logic [WORD_WIDTH-1:0]            in_word
);
    import window_pkg::*;

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,   // read requested, waiting for grant.
        F_WAIT,  // read data on rdata this cycle.
        F_HOLD   // word offered downstream.
    } fetch_state_t;

    fetch_state_t          state;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [BLK_WIDTH-1:0]  left_q;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state  <= F_IDLE;
            addr_q <= '0;
            left_q <= '0;
        end else begin
            case (state)
                F_IDLE: if (launch) begin
                    addr_q <= in_base;
                    left_q <= blocks_1;
                    state  <= F_REQ;
                end
                F_REQ: if (fetch_grant) state <= F_WAIT;
                F_WAIT: state <= F_HOLD;
                F_HOLD: if (in_ready) begin
                    addr_q <= addr_q + 1'b1;
                    left_q <= left_q - 1'b1;
                    state  <= (left_q == '0) ? F_IDLE : F_REQ;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == F_WAIT) in_word <= rdata;
    end

    assign in_valid        = (state == F_HOLD);
    assign fetch_valid     = (state == F_REQ);
    assign fetch_req.we    = 1'b0;
    assign fetch_req.addr  = addr_q;
    assign fetch_req.wdata = '0;

    // a fetched word must come from a loaded location.
    assert property (@(posedge aclk) disable iff (!rst_n)
        state == F_WAIT |-> !$isunknown(rdata))
    else $error("pixel_fetch: fetched word is unknown.");

endmodule

//--- src/shift_buffer.sv
`timescale 1ns/1ps

module shift_buffer #(
    parameter int DATA_WIDTH   = window_pkg::DATA_WIDTH,
    parameter int CONV_UNITS   = window_pkg::CONV_UNITS,
    parameter int KERNEL_H_MAX = window_pkg::KERNEL_H_MAX
) (
    input  logic                                              aclk,
    input  logic                                              rst_n,
    input  logic                                              launch,
    input  logic [window_pkg::KH_WIDTH-1:0]                   kernel_h_1,
    input  logic [window_pkg::BLK_WIDTH-1:0]                  blocks_1,
    input  logic                                              is_relu,
    input  logic                                              in_valid,
    input  logic [DATA_WIDTH*(CONV_UNITS+KERNEL_H_MAX-1)-1:0] in_word,
    input  logic                                              out_ready,
    output logic                                              in_ready,
    output logic                                              out_valid,
    output window_pkg::win_beat_t                             out_beat
);
    import window_pkg::*;

    localparam int IN_W  = DATA_WIDTH * (CONV_UNITS + KERNEL_H_MAX - 1);
    localparam int OUT_W = DATA_WIDTH * CONV_UNITS;

    logic [IN_W-1:0]      word_q;
    logic                 full_q;
    logic [KH_WIDTH-1:0]  tap_q;
    logic [BLK_WIDTH-1:0] word_idx;   // index of the held word in the job.
    logic                 last_tap;
    logic                 out_fire;
    logic                 in_fire;
    logic [IN_W-1:0]      shifted;
    logic [OUT_W-1:0]     out_data;

    assign last_tap  = (tap_q == kernel_h_1);
    assign out_fire  = full_q & out_ready;
    assign in_ready  = ~full_q | (out_fire & last_tap);  // refill behind the final tap.
    assign in_fire   = in_valid & in_ready;
    assign out_valid = full_q;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            full_q   <= 1'b0;
            tap_q    <= '0;
            word_idx <= '1;
        end else begin
            if (launch) begin
                word_idx <= '1;  // first accepted word wraps to zero.
            end else if (in_fire) begin
                word_idx <= word_idx + 1'b1;
            end

            if (in_fire) begin
                full_q <= 1'b1;
            end else if (out_fire && last_tap) begin
                full_q <= 1'b0;
            end

            if (out_fire) begin
                tap_q <= last_tap ? '0 : tap_q + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (in_fire) word_q <= in_word;
    end

    // tap s starts at pixel s of the held word.
    assign shifted = word_q >> (tap_q * DATA_WIDTH);

    for (genvar j = 0; j < CONV_UNITS; j++) begin : g_pix
        logic [DATA_WIDTH-1:0] pix;

        assign pix = shifted[j*DATA_WIDTH +: DATA_WIDTH];
        assign out_data[j*DATA_WIDTH +: DATA_WIDTH] =
            (is_relu && pix[DATA_WIDTH-1]) ? '0 : pix;
    end

    assign out_beat.data  = out_data;
    assign out_beat.shift = tap_q;
    assign out_beat.last  = last_tap && (word_idx == blocks_1);

    assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("shift_buffer: out_beat changed under back-pressure.");

endmodule

//--- src/window_store.sv
`timescale 1ns/1ps

module window_store #(
    parameter int ADDR_WIDTH = window_pkg::ADDR_WIDTH
) (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  launch,
    input  logic [ADDR_WIDTH-1:0] out_base,
    input  logic                  win_valid,
    input  window_pkg::win_beat_t win_beat,
    input  logic                  store_grant,
    output logic                  win_ready,
    output logic                  store_valid,
    output window_pkg::mem_req_t  store_req,
    output logic                  job_end
);
    import window_pkg::*;

    logic [ADDR_WIDTH-1:0] count_q;
    logic                  fire;

    // the stream moves only when the memory port is ours.
    assign win_ready   = store_grant;
    assign store_valid = win_valid;
    assign fire        = win_valid & store_grant;

    always_comb begin
        store_req.we    = win_valid;
        store_req.addr  = out_base + count_q;
        store_req.wdata = {{(IN_WIDTH-OUT_WIDTH){1'b0}}, win_beat.data};
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (launch) begin
            count_q <= '0;
        end else if (fire) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign job_end = fire & win_beat.last;  // high with the final write.

endmodule

//--- src/window_engine.sv
`timescale 1ns/1ps

module window_engine #(
    parameter int DATA_WIDTH   = window_pkg::DATA_WIDTH,
    parameter int CONV_UNITS   = window_pkg::CONV_UNITS,
    parameter int KERNEL_H_MAX = window_pkg::KERNEL_H_MAX,
    parameter int ADDR_WIDTH   = window_pkg::ADDR_WIDTH
) (
    input  logic                                              aclk,
    input  logic                                              rst_n,
    input  logic                                              start,
    input  window_pkg::conv_cfg_t                             job_cfg,
    input  logic                                              host_valid,
    input  window_pkg::mem_req_t                              host_req,
    output logic                                              host_grant,
    output logic [DATA_WIDTH*(CONV_UNITS+KERNEL_H_MAX-1)-1:0] host_rdata,
    output logic                                              busy,
    output logic                                              done
);
    import window_pkg::*;

    localparam int WORD_WIDTH = DATA_WIDTH * (CONV_UNITS + KERNEL_H_MAX - 1);

    conv_cfg_t             cfg_q;
    logic                  busy_q;
    logic                  done_q;
    logic                  launch_q;
    logic                  accept;

    logic                  mem_en;
    mem_req_t              mem_req;
    logic [WORD_WIDTH-1:0] mem_rdata;

    logic                  store_valid;
    logic                  store_grant;
    mem_req_t              store_req;
    logic                  fetch_valid;
    logic                  fetch_grant;
    mem_req_t              fetch_req;

    logic                  in_valid;
    logic                  in_ready;
    logic [WORD_WIDTH-1:0] in_word;
    logic                  win_valid;
    logic                  win_ready;
    win_beat_t             win_beat;
    logic                  job_end;

    assign accept = start & ~busy_q;  // start while busy is dropped.

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            launch_q <= 1'b0;
        end else begin
            launch_q <= accept;
            done_q   <= job_end;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (job_end) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) cfg_q <= job_cfg;
    end

    assign busy       = busy_q;
    assign done       = done_q;
    assign host_rdata = mem_rdata;

    buffer_mem #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .WORD_WIDTH (WORD_WIDTH)
    ) buffer_mem_inst (
        .aclk    (aclk),
        .mem_req (mem_req),
        .mem_en  (mem_en),
        .rdata   (mem_rdata)
    );

    mem_arbiter mem_arbiter_inst (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .store_valid (store_valid),
        .store_req   (store_req),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .host_valid  (host_valid),
        .host_req    (host_req),
        .store_grant (store_grant),
        .fetch_grant (fetch_grant),
        .host_grant  (host_grant),
        .mem_en      (mem_en),
        .mem_req     (mem_req)
    );

    pixel_fetch #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .WORD_WIDTH (WORD_WIDTH)
    ) pixel_fetch_inst (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .launch      (launch_q),
        .in_base     (cfg_q.in_base),
        .blocks_1    (cfg_q.blocks_1),
        .fetch_grant (fetch_grant),
        .rdata       (mem_rdata),
        .in_ready    (in_ready),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .in_valid    (in_valid),
        .in_word     (in_word)
    );

    shift_buffer #(
        .DATA_WIDTH   (DATA_WIDTH),
        .CONV_UNITS   (CONV_UNITS),
        .KERNEL_H_MAX (KERNEL_H_MAX)
    ) shift_buffer_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .launch     (launch_q),
        .kernel_h_1 (cfg_q.kernel_h_1),
        .blocks_1   (cfg_q.blocks_1),
        .is_relu    (cfg_q.is_relu),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .out_ready  (win_ready),
        .in_ready   (in_ready),
        .out_valid  (win_valid),
        .out_beat   (win_beat)
    );

    window_store #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) window_store_inst (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .launch      (launch_q),
        .out_base    (cfg_q.out_base),
        .win_valid   (win_valid),
        .win_beat    (win_beat),
        .store_grant (store_grant),
        .win_ready   (win_ready),
        .store_valid (store_valid),
        .store_req   (store_req),
        .job_end     (job_end)
    );

    // a job can only finish after it was launched.
    assert property (@(posedge aclk) disable iff (!rst_n)
        done |-> $past(busy))
    else $error("window_engine: done without a running job.");

endmodule

//--- sim/window_engine_tb.sv
`timescale 1ns/1ps

module window_engine_tb;
    import window_pkg::*;

    localparam int NUM_ROWS    = 5;
    localparam int DEPTH       = 2**ADDR_WIDTH;
    localparam int CYCLE_LIMIT = 40 * NUM_ROWS + 2 * NUM_ROWS * (2 * DEPTH + 1);

    typedef struct packed {
        logic [KH_WIDTH-1:0]   kernel_h_1;
        logic [BLK_WIDTH-1:0]  blocks_1;
        logic                  is_relu;
        logic [ADDR_WIDTH-1:0] in_base;
        logic [ADDR_WIDTH-1:0] out_base;
    } job_row_t;

    logic                aclk;
    logic                rst_n;
    logic                start;
    conv_cfg_t           job_cfg;
    logic                host_valid;
    mem_req_t            host_req;
    logic                host_grant;
    logic [IN_WIDTH-1:0] host_rdata;
    logic                busy;
    logic                done;

    job_row_t            jobs [NUM_ROWS];
    logic [IN_WIDTH-1:0] mem_model [DEPTH];  // contents as loaded by the host.
    logic [IN_WIDTH-1:0] exp_mem [DEPTH];
    integer              seed;
    int                  done_count = 0;
    int                  cycle_count = 0;

    window_engine #(
        .DATA_WIDTH   (DATA_WIDTH),
        .CONV_UNITS   (CONV_UNITS),
        .KERNEL_H_MAX (KERNEL_H_MAX),
        .ADDR_WIDTH   (ADDR_WIDTH)
    ) window_engine_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .start      (start),
        .job_cfg    (job_cfg),
        .host_valid (host_valid),
        .host_req   (host_req),
        .host_grant (host_grant),
        .host_rdata (host_rdata),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    always @(negedge aclk) begin
        if (rst_n && done) begin
            done_count++;
            check_value("busy", busy, 0);  // busy falls with done.
        end
    end

    task automatic tick();
        @(posedge aclk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [IN_WIDTH-1:0] actual,
                               input logic [IN_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // holds the request until granted, read data is taken after the grant edge.
    task automatic host_access(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                               input logic [IN_WIDTH-1:0] wdata,
                               output logic [IN_WIDTH-1:0] rdata, output int waited);
        logic granted;

        host_valid     = 1'b1;
        host_req.we    = we;
        host_req.addr  = addr;
        host_req.wdata = wdata;
        waited         = 0;
        do begin
            @(negedge aclk);
            granted = host_grant;
            if (!granted) waited++;
            tick();
        end while (!granted);
        host_valid = 1'b0;
        host_req   = '0;
        rdata      = host_rdata;
    endtask

    task automatic load_memory();
        logic [IN_WIDTH-1:0] word;
        logic [IN_WIDTH-1:0] rd;
        int                  waited;

        for (int a = 0; a < DEPTH; a++) begin
            word = {$random(seed), $random(seed), $random(seed)};
            mem_model[a] = word;
            host_access(1'b1, ADDR_WIDTH'(a), word, rd, waited);
        end
    endtask

    function automatic logic [IN_WIDTH-1:0] expected_word(input logic [IN_WIDTH-1:0] src,
                                                          input int s, input logic relu);
        logic [IN_WIDTH-1:0]   res;
        logic [DATA_WIDTH-1:0] pix;

        res = '0;
        for (int j = 0; j < CONV_UNITS; j++) begin
            pix = src[(s + j) * DATA_WIDTH +: DATA_WIDTH];
            if (relu && pix[DATA_WIDTH-1]) pix = '0;
            res[j * DATA_WIDTH +: DATA_WIDTH] = pix;
        end
        return res;
    endfunction

    task automatic run_job(input int row);
        conv_cfg_t           cfg;
        logic [IN_WIDTH-1:0] rd;
        int                  waited;

        cfg            = '0;
        cfg.kernel_h_1 = jobs[row].kernel_h_1;
        cfg.blocks_1   = jobs[row].blocks_1;
        cfg.is_relu    = jobs[row].is_relu;
        cfg.in_base    = jobs[row].in_base;
        cfg.out_base   = jobs[row].out_base;
        job_cfg = cfg;
        start   = 1'b1;
        tick();
        check_value("busy", busy, 1);
        job_cfg = ~cfg;  // second start with a bogus job, must be ignored.
        tick();
        start   = 1'b0;
        job_cfg = '0;
        // the fetcher owns the port in this cycle.
        host_access(1'b0, cfg.in_base, '0, rd, waited);
        check_value("host_grant wait", waited != 0, 1);
        check_value("host_rdata", rd, mem_model[cfg.in_base]);
        while (done_count <= row) tick();
    endtask

    task automatic read_back(input int row);
        job_row_t            r;
        logic [IN_WIDTH-1:0] src;
        logic [IN_WIDTH-1:0] rd;
        int                  waited;
        int                  taps;
        int                  addr;
        int                  neg;

        r    = jobs[row];
        taps = r.kernel_h_1 + 1;
        neg  = 0;
        for (int a = 0; a < DEPTH; a++) begin
            exp_mem[a] = mem_model[a];
        end
        for (int w = 0; w <= r.blocks_1; w++) begin
            src = mem_model[(r.in_base + w) % DEPTH];
            for (int s = 0; s < taps; s++) begin
                addr = (r.out_base + w * taps + s) % DEPTH;
                exp_mem[addr] = expected_word(src, s, r.is_relu);
                for (int j = 0; j < CONV_UNITS; j++) begin
                    if (src[(s + j) * DATA_WIDTH + DATA_WIDTH - 1]) neg++;
                end
            end
        end
        // the clamp and the pass-through paths both need negative input pixels.
        check_value("negative input pixels", neg != 0, 1);
        for (int a = 0; a < DEPTH; a++) begin
            host_access(1'b0, ADDR_WIDTH'(a), '0, rd, waited);
            check_value($sformatf("host_rdata at 0x%0h", a), rd, exp_mem[a]);
        end
        check_value("done count", done_count, row + 1);
    endtask

    initial begin
        seed       = 32'hce74;
        rst_n      = 1'b0;
        start      = 1'b0;
        job_cfg    = '0;
        host_valid = 1'b0;
        host_req   = '0;

        // kernel_h_1, blocks_1, is_relu, in_base, out_base.
        jobs[0] = {2'd0, 6'd3, 1'b0, 6'd0, 6'd8};
        jobs[1] = {2'd1, 6'd2, 1'b1, 6'd4, 6'd20};
        jobs[2] = {2'd2, 6'd3, 1'b0, 6'd30, 6'd40};
        jobs[3] = {2'd2, 6'd1, 1'b1, 6'd60, 6'd2};
        jobs[4] = {2'd1, 6'd4, 1'b0, 6'd10, 6'd52};

        repeat (3) @(posedge aclk);
        #10;
        rst_n = 1'b1;
        @(negedge aclk);
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("host_grant", host_grant, 0);
        tick();

        for (int row = 0; row < NUM_ROWS; row++) begin
            load_memory();
            run_job(row);
            read_back(row);
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- window_engine.f
src/window_pkg.sv
src/buffer_mem.sv
src/mem_arbiter.sv
src/pixel_fetch.sv
src/shift_buffer.sv
src/window_store.sv
src/window_engine.sv
sim/window_engine_tb.sv

//--- Bender.yml
package:
  name: window_engine

sources:
  - files:
      - src/window_pkg.sv
      - src/buffer_mem.sv
      - src/mem_arbiter.sv
      - src/pixel_fetch.sv
      - src/shift_buffer.sv
      - src/window_store.sv
      - src/window_engine.sv
  - target: simulation
    files:
      - sim/window_engine_tb.sv
